// ==== adpcma_pkg.sv ====
`default_nettype none

package adpcma_pkg;

    localparam int NUM_CH_MAX = 8;  // array depth, ch field is 3 bits

    typedef struct packed {
        logic [2:0] ch;
        logic [1:0] phase;  // 0 fetch, 1 latch, 2 decode
    } slot_t;

    typedef enum logic [2:0] {
        WR_START,
        WR_END,
        WR_LRACL,
        WR_KON,
        WR_KOFF
    } wr_kind_t;

    typedef struct packed {
        logic [2:0]  ch;
        wr_kind_t    kind;
        logic [11:0] value;  // block number or lracl byte
    } chan_wr_t;

    typedef struct packed {
        logic signed [15:0] l;
        logic signed [15:0] r;
    } stereo_t;

    localparam logic [10:0] step_table [49] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    localparam logic signed [4:0] index_adj [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

endpackage

`default_nettype wire

// ==== adpcma_slot_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_slot_timer #(
    parameter int NUM_CH = 6
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    output adpcma_pkg::slot_t  slot,
    output logic               frame_end
);

    logic last_ch;

    assign last_ch   = slot.ch == 3'(NUM_CH - 1);
    assign frame_end = last_ch && slot.phase == 2'd2;  // last tick of the frame

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (cen) begin
            if (slot.phase == 2'd2) begin
                slot.phase <= 2'd0;
                slot.ch    <= last_ch ? 3'd0 : slot.ch + 3'd1;
            end else begin
                slot.phase <= slot.phase + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== adpcma_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_ctrl_fsm #(
    parameter int NUM_CH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  adpcma_pkg::slot_t     slot,
    input  logic                  up_start,
    input  logic                  up_end,
    input  logic                  up_lracl,
    input  logic [2:0]            up_addr,
    input  logic [2:0]            up_ch_lr,
    input  logic [11:0]           addr_in,
    input  logic [7:0]            lracl_in,
    input  logic                  aon_wr,
    input  logic [7:0]            aon_cmd,
    output adpcma_pkg::chan_wr_t  wr,
    output logic                  wr_valid
);

    typedef enum logic [1:0] {IDLE, WAIT_SLOT, APPLY} state_t;

    state_t                state;
    adpcma_pkg::chan_wr_t  pend_start, pend_end, pend_lr;
    logic                  has_start, has_end, has_lr;
    logic [NUM_CH-1:0]     kon_mask, koff_mask;  // channels still to be keyed
    logic [2:0]            kon_ch, koff_ch, prev_ch;

    // lowest channel still set in a key mask
    function automatic logic [2:0] first_ch(input logic [NUM_CH-1:0] m);
        logic [2:0] r;
        r = '0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (m[i]) r = 3'(i);
        end
        return r;
    endfunction

    assign kon_ch   = first_ch(kon_mask);
    assign koff_ch  = first_ch(koff_mask);
    assign prev_ch  = (wr.ch == 3'd0) ? 3'(NUM_CH - 1) : wr.ch - 3'd1;
    assign wr_valid = state == APPLY;  // held over the target fetch tick

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            wr         <= '0;
            pend_start <= '0;
            pend_end   <= '0;
            pend_lr    <= '0;
            has_start  <= 1'b0;
            has_end    <= 1'b0;
            has_lr     <= 1'b0;
            kon_mask   <= '0;
            koff_mask  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    state <= WAIT_SLOT;
                    if (has_start) begin
                        wr        <= pend_start;
                        has_start <= 1'b0;
                    end else if (has_end) begin
                        wr      <= pend_end;
                        has_end <= 1'b0;
                    end else if (has_lr) begin
                        wr     <= pend_lr;
                        has_lr <= 1'b0;
                    end else if (|koff_mask) begin
                        wr <= '{ch: koff_ch, kind: adpcma_pkg::WR_KOFF, value: '0};
                        koff_mask[koff_ch] <= 1'b0;
                    end else if (|kon_mask) begin
                        wr <= '{ch: kon_ch, kind: adpcma_pkg::WR_KON, value: '0};
                        kon_mask[kon_ch] <= 1'b0;
                    end else begin
                        state <= IDLE;
                    end
                end
                WAIT_SLOT: begin
                    // last tick before the target channel's fetch
                    if (cen && slot.phase == 2'd2 && slot.ch == prev_ch) state <= APPLY;
                end
                APPLY: begin
                    if (cen) state <= IDLE;
                end
                default: state <= IDLE;
            endcase

            // host writes replace whatever is still pending
            if (up_start) begin
                pend_start <= '{ch: up_addr, kind: adpcma_pkg::WR_START, value: addr_in};
                has_start  <= 1'b1;
            end
            if (up_end) begin
                pend_end <= '{ch: up_addr, kind: adpcma_pkg::WR_END, value: addr_in};
                has_end  <= 1'b1;
            end
            if (up_lracl) begin
                pend_lr <= '{ch: up_ch_lr, kind: adpcma_pkg::WR_LRACL,
                             value: {4'd0, lracl_in}};
                has_lr  <= 1'b1;
            end
            if (aon_wr) begin
                if (aon_cmd[7]) begin
                    koff_mask <= aon_cmd[NUM_CH-1:0];
                end else begin
                    kon_mask <= aon_cmd[NUM_CH-1:0];
                end
            end
        end
    end

    a_apply_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> slot.phase == 2'd0 && slot.ch == wr.ch);

endmodule

`default_nettype wire

// ==== adpcma_addr_cnt.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_addr_cnt #(
    parameter int NUM_CH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  adpcma_pkg::slot_t     slot,
    input  adpcma_pkg::chan_wr_t  wr,
    input  logic                  wr_valid,
    output logic [19:0]           addr,
    output logic [3:0]            bank,
    output logic                  roe_n,
    output logic                  nibble_sel,
    output logic                  chon,
    output logic                  key_rst
);

    logic [11:0] start_blk [adpcma_pkg::NUM_CH_MAX];
    logic [11:0] end_blk   [adpcma_pkg::NUM_CH_MAX];
    logic [19:0] cur       [adpcma_pkg::NUM_CH_MAX];  // byte address
    logic [adpcma_pkg::NUM_CH_MAX-1:0] nib, active;
    logic        kon, koff, fetch_on, last_byte;
    logic [19:0] fetch_addr;

    assign kon        = wr_valid && wr.kind == adpcma_pkg::WR_KON;
    assign koff       = wr_valid && wr.kind == adpcma_pkg::WR_KOFF;
    assign fetch_on   = kon || (active[slot.ch] && !koff);
    assign fetch_addr = kon ? {start_blk[slot.ch], 8'h00} : cur[slot.ch];
    assign last_byte  = cur[slot.ch] == {end_blk[slot.ch], 8'hff};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                active[i] <= 1'b0;
            end
            roe_n   <= 1'b1;
            chon    <= 1'b0;
            key_rst <= 1'b0;
        end else if (cen) begin
            roe_n <= 1'b1;  // enable lasts a single tick
            if (slot.phase == 2'd0) begin
                roe_n   <= !fetch_on;
                chon    <= fetch_on;  // held for latch and decode
                key_rst <= kon;
                if (kon) active[slot.ch] <= 1'b1;
                if (koff) active[slot.ch] <= 1'b0;
            end else if (slot.phase == 2'd1 && chon && nibble_sel && last_byte) begin
                active[slot.ch] <= 1'b0;  // both nibbles of the end byte done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (slot.phase == 2'd0) begin
                addr       <= fetch_addr;
                bank       <= fetch_addr[19:16];
                nibble_sel <= kon ? 1'b0 : nib[slot.ch];
                if (wr_valid && wr.kind == adpcma_pkg::WR_START) start_blk[wr.ch] <= wr.value;
                if (wr_valid && wr.kind == adpcma_pkg::WR_END) end_blk[wr.ch] <= wr.value;
                if (kon) begin
                    cur[slot.ch] <= fetch_addr;
                    nib[slot.ch] <= 1'b0;
                end
            end else if (slot.phase == 2'd1 && chon) begin
                if (nibble_sel) begin
                    nib[slot.ch] <= 1'b0;
                    cur[slot.ch] <= cur[slot.ch] + 20'd1;  // next byte
                end else begin
                    nib[slot.ch] <= 1'b1;
                end
            end
        end
    end

    a_roe_active: assert property (@(posedge clk) disable iff (!rst_n)
        !roe_n |-> slot.phase == 2'd1 && active[slot.ch]);

endmodule

`default_nettype wire

// ==== adpcma_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_decoder #(
    parameter int NUM_CH = 6
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  adpcma_pkg::slot_t  slot,
    input  logic [3:0]         nibble,
    input  logic               chon,
    input  logic               key_rst,
    output logic signed [11:0] sample,
    output logic               sample_valid
);

    logic signed [11:0] acc [adpcma_pkg::NUM_CH_MAX];
    logic [5:0]         idx [adpcma_pkg::NUM_CH_MAX];
    logic signed [11:0] acc_in, acc_nx;
    logic [5:0]         idx_in, idx_nx;
    logic [10:0]        step;
    logic [14:0]        prod;
    logic [11:0]        diff;
    logic signed [13:0] sum;
    logic signed [7:0]  idx_sum;

    // key-on starts the channel from a cleared state
    assign acc_in = key_rst ? 12'sd0 : acc[slot.ch];
    assign idx_in = key_rst ? 6'd0 : idx[slot.ch];

    always_comb begin
        step    = adpcma_pkg::step_table[idx_in];
        prod    = 15'({nibble[2:0], 1'b1}) * 15'(step);  // (2n+1) * s
        diff    = 12'(prod >> 3);
        sum     = nibble[3] ? acc_in - $signed({2'b00, diff})
                            : acc_in + $signed({2'b00, diff});
        if (sum > 14'sd2047) begin
            acc_nx = 12'sd2047;
        end else if (sum < -14'sd2048) begin
            acc_nx = -12'sd2048;
        end else begin
            acc_nx = sum[11:0];
        end
        idx_sum = $signed({2'b00, idx_in}) + adpcma_pkg::index_adj[nibble[2:0]];
        if (idx_sum < 8'sd0) begin
            idx_nx = 6'd0;
        end else if (idx_sum > 8'sd48) begin
            idx_nx = 6'd48;
        end else begin
            idx_nx = idx_sum[5:0];
        end
    end

    assign sample       = chon ? acc_nx : 12'sd0;  // silent when inactive
    assign sample_valid = cen && slot.phase == 2'd2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
        end else if (sample_valid && chon) begin
            acc[slot.ch] <= acc_nx;
            idx[slot.ch] <= idx_nx;
        end
    end

endmodule

`default_nettype wire

// ==== adpcma_gain.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_gain #(
    parameter int NUM_CH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  adpcma_pkg::slot_t     slot,
    input  adpcma_pkg::chan_wr_t  wr,
    input  logic                  wr_valid,
    input  logic [5:0]            atl,
    input  logic signed [11:0]    sample,
    input  logic                  sample_valid,
    output adpcma_pkg::stereo_t   contrib,
    output logic                  contrib_valid
);

    logic [4:0]                        level [adpcma_pkg::NUM_CH_MAX];
    logic [adpcma_pkg::NUM_CH_MAX-1:0] en_l, en_r;
    logic [6:0]                        vol_sum;
    logic [5:0]                        vol;
    logic signed [18:0]                scaled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                level[i] <= '0;
                en_l[i]  <= 1'b0;
                en_r[i]  <= 1'b0;
            end
        end else if (cen && wr_valid && wr.kind == adpcma_pkg::WR_LRACL) begin
            level[wr.ch] <= wr.value[4:0];
            en_l[wr.ch]  <= wr.value[7];
            en_r[wr.ch]  <= wr.value[6];
        end
    end

    // linear stand-in for the attenuation tables
    assign vol_sum = 7'(level[slot.ch]) + 7'(atl);
    assign vol     = (vol_sum > 7'd31) ? 6'(vol_sum - 7'd31) : 6'd0;
    assign scaled  = sample * $signed({1'b0, 7'(vol) + 7'd1});

    assign contrib.l     = en_l[slot.ch] ? scaled[17:2] : 16'sd0;  // >>> 2
    assign contrib.r     = en_r[slot.ch] ? scaled[17:2] : 16'sd0;
    assign contrib_valid = sample_valid;

endmodule

`default_nettype wire

// ==== adpcma_mix.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_mix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 frame_end,
    input  adpcma_pkg::stereo_t  contrib,
    input  logic                 contrib_valid,
    output adpcma_pkg::stereo_t  pcm,
    output logic                 sample_stb
);

    logic signed [18:0] acc_l, acc_r, sum_l, sum_r;

    function automatic logic signed [15:0] sat16(input logic signed [18:0] v);
        if (v > 19'sd32767) return 16'sh7fff;
        if (v < -19'sd32768) return 16'sh8000;
        return v[15:0];
    endfunction

    always_comb begin
        sum_l = acc_l;
        sum_r = acc_r;
        if (contrib_valid) begin
            sum_l = acc_l + 19'(contrib.l);
            sum_r = acc_r + 19'(contrib.r);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l      <= '0;
            acc_r      <= '0;
            pcm        <= '0;
            sample_stb <= 1'b0;
        end else begin
            sample_stb <= cen && frame_end;
            if (cen) begin
                if (frame_end) begin
                    pcm.l <= sat16(sum_l);  // last channel included
                    pcm.r <= sat16(sum_r);
                    acc_l <= '0;
                    acc_r <= '0;
                end else begin
                    acc_l <= sum_l;
                    acc_r <= sum_r;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== adpcma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcma_top #(
    parameter int NUM_CH = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 up_start,
    input  logic                 up_end,
    input  logic                 up_lracl,
    input  logic [2:0]           up_addr,
    input  logic [2:0]           up_ch_lr,
    input  logic [11:0]          addr_in,
    input  logic [7:0]           lracl_in,
    input  logic [5:0]           atl,
    input  logic                 aon_wr,
    input  logic [7:0]           aon_cmd,
    input  logic [7:0]           datain,
    output logic [19:0]          addr,
    output logic [3:0]           bank,
    output logic                 roe_n,
    output adpcma_pkg::stereo_t  pcm,
    output logic                 sample_stb
);

    adpcma_pkg::slot_t     slot;
    adpcma_pkg::chan_wr_t  wr;
    adpcma_pkg::stereo_t   contrib;
    logic                  frame_end, wr_valid, nibble_sel, chon, key_rst;
    logic                  sample_valid, contrib_valid;
    logic [3:0]            nibble;
    logic signed [11:0]    sample;

    always_ff @(posedge clk) begin
        if (cen && slot.phase == 2'd1) begin
            nibble <= nibble_sel ? datain[3:0] : datain[7:4];  // high nibble first
        end
    end

    adpcma_slot_timer #(.NUM_CH(NUM_CH)) u_timer (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot), .frame_end(frame_end)
    );

    adpcma_ctrl_fsm #(.NUM_CH(NUM_CH)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot),
        .up_start(up_start), .up_end(up_end), .up_lracl(up_lracl),
        .up_addr(up_addr), .up_ch_lr(up_ch_lr), .addr_in(addr_in),
        .lracl_in(lracl_in), .aon_wr(aon_wr), .aon_cmd(aon_cmd),
        .wr(wr), .wr_valid(wr_valid)
    );

    adpcma_addr_cnt #(.NUM_CH(NUM_CH)) u_addr (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot), .wr(wr), .wr_valid(wr_valid),
        .addr(addr), .bank(bank), .roe_n(roe_n), .nibble_sel(nibble_sel),
        .chon(chon), .key_rst(key_rst)
    );

    adpcma_decoder #(.NUM_CH(NUM_CH)) u_dec (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot), .nibble(nibble),
        .chon(chon), .key_rst(key_rst), .sample(sample), .sample_valid(sample_valid)
    );

    adpcma_gain #(.NUM_CH(NUM_CH)) u_gain (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot), .wr(wr), .wr_valid(wr_valid),
        .atl(atl), .sample(sample), .sample_valid(sample_valid),
        .contrib(contrib), .contrib_valid(contrib_valid)
    );

    adpcma_mix u_mix (
        .clk(clk), .rst_n(rst_n), .cen(cen), .frame_end(frame_end),
        .contrib(contrib), .contrib_valid(contrib_valid),
        .pcm(pcm), .sample_stb(sample_stb)
    );

endmodule

`default_nettype wire

// ==== tb_adpcma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adpcma;

    localparam int NCH        = 6;
    localparam int SEED       = 68357;
    localparam int FRAME_CLKS = 36;  // 18 ticks, cen every second clk
    localparam int STB_TMO    = 80;

    logic                clk, rst_n, cen;
    logic                up_start, up_end, up_lracl, aon_wr;
    logic [2:0]          up_addr, up_ch_lr;
    logic [11:0]         addr_in;
    logic [7:0]          lracl_in, aon_cmd, datain;
    logic [5:0]          atl;
    logic [19:0]         addr;
    logic [3:0]          bank;
    logic                roe_n, sample_stb;
    adpcma_pkg::stereo_t pcm, exp_pcm;

    logic [7:0] rom [4096];
    int         blk_start [NCH], blk_end [NCH];
    int         kon_at [NCH], koff_at [NCH], lr_at [NCH];
    logic [7:0] lr_val [NCH];
    logic       m_act [NCH], m_nib [NCH], m_enl [NCH], m_enr [NCH];
    int         m_cur [NCH], m_acc [NCH], m_idx [NCH], m_lvl [NCH];
    logic [NCH-1:0] off_mask;  // keyed-off channels under watch
    int         errors, checks, frame_idx, cyc, last_stb, roe_lo;

    adpcma_top #(.NUM_CH(NCH)) u_adpcma_top (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .up_start(up_start), .up_end(up_end), .up_lracl(up_lracl),
        .up_addr(up_addr), .up_ch_lr(up_ch_lr), .addr_in(addr_in),
        .lracl_in(lracl_in), .atl(atl), .aon_wr(aon_wr), .aon_cmd(aon_cmd),
        .datain(datain), .addr(addr), .bank(bank), .roe_n(roe_n),
        .pcm(pcm), .sample_stb(sample_stb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    always @(posedge clk) begin
        #2;
        cen = !cen;  // one tick every second clk
        datain = (addr[19:12] == 8'd0) ? rom[addr[11:0]] : 8'h00;  // async ROM
    end

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    // one frame of the channel model, in slot order
    function automatic adpcma_pkg::stereo_t ref_frame(input int f);
        adpcma_pkg::stereo_t res;
        int sum_l, sum_r, n, s, diff, vol, part;
        logic [7:0] b;
        sum_l = 0;
        sum_r = 0;
        for (int c = 0; c < NCH; c++) begin
            if (lr_at[c] == f) begin
                m_lvl[c] = int'(lr_val[c][4:0]);
                m_enl[c] = lr_val[c][7];
                m_enr[c] = lr_val[c][6];
            end
            if (koff_at[c] == f) m_act[c] = 1'b0;
            if (kon_at[c] == f) begin
                m_act[c] = 1'b1;
                m_cur[c] = blk_start[c] * 256;
                m_nib[c] = 1'b0;
                m_acc[c] = 0;
                m_idx[c] = 0;
            end
            if (m_act[c]) begin
                b = rom[m_cur[c]];
                n = m_nib[c] ? int'(b[3:0]) : int'(b[7:4]);  // high nibble first
                s = int'(adpcma_pkg::step_table[m_idx[c]]);
                diff = ((2 * (n % 8) + 1) * s) / 8;
                m_acc[c] = clamp((n >= 8) ? m_acc[c] - diff : m_acc[c] + diff, -2048, 2047);
                m_idx[c] = clamp(m_idx[c] + int'(adpcma_pkg::index_adj[n % 8]), 0, 48);
                vol = clamp(63 - (31 - m_lvl[c]) - (63 - int'(atl)), 0, 63);
                part = (m_acc[c] * (vol + 1)) >>> 2;
                if (m_enl[c]) sum_l += part;
                if (m_enr[c]) sum_r += part;
                if (m_nib[c]) begin
                    if (m_cur[c] == blk_end[c] * 256 + 255) m_act[c] = 1'b0;
                    m_cur[c]++;
                end
                m_nib[c] = !m_nib[c];
            end
        end
        res.l = 16'(clamp(sum_l, -32768, 32767));
        res.r = 16'(clamp(sum_r, -32768, 32767));
        return res;
    endfunction

    always @(posedge clk) begin
        cyc++;
        if (rst_n && sample_stb) begin
            exp_pcm = ref_frame(frame_idx);
            checks += 2;
            assert (pcm.l == exp_pcm.l) else begin
                $display("ERR pcm.l frame %0d: got %h, expected %h", frame_idx, pcm.l, exp_pcm.l);
                errors++;
            end
            assert (pcm.r == exp_pcm.r) else begin
                $display("ERR pcm.r frame %0d: got %h, expected %h", frame_idx, pcm.r, exp_pcm.r);
                errors++;
            end
            if (last_stb >= 0) begin
                checks++;
                assert (cyc - last_stb == FRAME_CLKS) else begin
                    $display("sample_stb came %0d clocks after the previous one", cyc - last_stb);
                    errors++;
                end
            end
            last_stb = cyc;
            frame_idx++;
        end
    end

    always @(posedge clk) begin
        if (rst_n && !roe_n) begin
            roe_lo++;
            checks++;
            assert (bank == addr[19:16]) else begin
                $display("ERR bank: got %h, expected %h", bank, addr[19:16]);
                errors++;
            end
            for (int c = 0; c < NCH; c++) begin
                if (off_mask[c] && frame_idx >= koff_at[c]) begin
                    checks++;
                    assert (int'(addr[19:8]) < blk_start[c] || int'(addr[19:8]) > blk_end[c])
                    else begin
                        $display("ROM read at %h for channel %0d after its key-off", addr, c);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic end_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // returns 2 ns after the clk that shows sample_stb
    task automatic wait_frame();
        int n;
        n = 0;
        @(posedge clk);
        while (!sample_stb && n < STB_TMO) begin
            @(posedge clk);
            n++;
        end
        if (sample_stb) begin
            #2;
        end else begin
            $display("timeout, no sample_stb within %0d clocks", STB_TMO);
            errors++;
            end_run();
        end
    endtask

    task automatic wait_frames(input int k);
        for (int i = 0; i < k; i++) begin
            wait_frame();
        end
    endtask

    task automatic set_atl(input logic [5:0] v);
        wait_frame();
        atl = v;
    endtask

    task automatic write_block(input int c, input int s, input int e);
        wait_frame();
        up_addr = 3'(c);
        addr_in = 12'(s);
        up_start = 1'b1;
        @(posedge clk);
        #2;
        up_start = 1'b0;
        addr_in = 12'(e);
        up_end = 1'b1;
        @(posedge clk);
        #2;
        up_end = 1'b0;
        blk_start[c] = s;
        blk_end[c] = e;
        wait_frames(2);
    endtask

    task automatic write_lracl(input int c, input logic [7:0] v);
        wait_frame();
        up_ch_lr = 3'(c);
        lracl_in = v;
        up_lracl = 1'b1;
        lr_val[c] = v;
        lr_at[c] = frame_idx + ((c == 0) ? 1 : 0);  // channel 0 slot has passed
        @(posedge clk);
        #2;
        up_lracl = 1'b0;
        wait_frame();
    endtask

    task automatic key_cmd(input logic [7:0] cmd);
        wait_frame();
        aon_cmd = cmd;
        aon_wr = 1'b1;
        for (int c = 0; c < NCH; c++) begin
            if (cmd[c] && cmd[7]) begin
                koff_at[c] = frame_idx + int'(cmd[0]);
                off_mask[c] = 1'b1;
            end else if (cmd[c]) begin
                kon_at[c] = frame_idx + int'(cmd[0]);
                off_mask[c] = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        aon_wr = 1'b0;
        wait_frame();
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e0;
        rst_n = 1'b0;
        cen = 1'b0;
        {up_start, up_end, up_lracl, aon_wr} = '0;
        {up_addr, up_ch_lr, addr_in, lracl_in, aon_cmd} = '0;
        atl = '0;
        datain = '0;
        {errors, checks, frame_idx, cyc, roe_lo} = '0;
        last_stb = -1;
        off_mask = '0;
        void'($urandom(SEED));
        for (int i = 0; i < 4096; i++) begin
            rom[i] = 8'($urandom());
        end
        for (int c = 0; c < NCH; c++) begin
            kon_at[c] = -1;
            koff_at[c] = -1;
            lr_at[c] = -1;
            {blk_start[c], blk_end[c], m_cur[c], m_acc[c], m_idx[c], m_lvl[c]} = '0;
            {m_act[c], m_nib[c], m_enl[c], m_enr[c]} = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e0 = errors;
        wait_frames(4);
        checks++;
        assert (roe_lo == 0) else begin
            $display("roe_n went low with no channel keyed on");
            errors++;
        end
        report("reset state", e0);

        e0 = errors;
        set_atl(6'd63);
        write_block(1, 2, 2);
        write_lracl(1, 8'hdf);
        key_cmd(8'h02);
        wait_frames(516);  // 512 nibbles plus silence
        checks++;
        assert (pcm == '0) else begin
            $display("ERR pcm: got %h, expected 00000000 after channel end", pcm);
            errors++;
        end
        report("one channel over one block", e0);

        e0 = errors;
        write_block(1, 3, 4);
        write_lracl(1, 8'h9f);  // left only
        key_cmd(8'h02);
        wait_frames(4);
        write_lracl(1, 8'h5f);  // right only
        wait_frames(4);
        write_lracl(1, 8'hdf);
        wait_frames(4);
        report("pan", e0);

        e0 = errors;
        for (int lv = 31; lv >= 0; lv -= 10) begin
            write_lracl(1, 8'hc0 | 8'(lv));
            set_atl(6'd63);
            wait_frames(2);
            set_atl(6'd45);
            wait_frames(2);
            set_atl(6'd32);
            wait_frames(2);
        end
        report("level and total level", e0);

        e0 = errors;
        set_atl(6'd63);
        for (int c = 0; c < NCH; c++) begin
            write_block(c, 6 + c, 6 + c);
            write_lracl(c, 8'hdf);
        end
        key_cmd(8'h3f);
        wait_frames(24);
        report("six channel mix", e0);

        e0 = errors;
        key_cmd(8'h88);  // key-off channel 3
        wait_frames(12);
        report("key-off", e0);

        end_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
adpcma_pkg.sv
adpcma_slot_timer.sv
adpcma_ctrl_fsm.sv
adpcma_addr_cnt.sv
adpcma_decoder.sv
adpcma_gain.sv
adpcma_mix.sv
adpcma_top.sv
tb_adpcma.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ADPCM-A testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_adpcma \
    -o tb_adpcma_sim
./obj_dir/tb_adpcma_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    exit 1
fi
